// File: icache_pkg.sv
/*
 * shared geometry and bus types for a direct-mapped 4 KB instruction cache
 * with 16-byte lines. the address split assumes 32-bit fetch addresses and
 * that tag, index and offset widths add up to exactly 32 bits
 */
`default_nettype none

package icache_pkg;

	// ========================================
	// cache geometry
	// ========================================

	// bytes held by one cache line
	localparam int line_bytes = 16;
	// number of lines, one per index in a direct-mapped array
	localparam int num_sets = 256;
	// stored tag width, address bits 31 down to 12
	localparam int tag_w = 20;
	// size of the instruction window handed back to the fetch unit
	localparam int insn_bytes = 8;

	// derived widths for the address split and the fill beat counter
	localparam int idx_w = $clog2(num_sets);
	localparam int off_w = $clog2(line_bytes);
	localparam int line_words = line_bytes / 4;
	localparam int beat_w = $clog2(line_words);

	// AXI response code for a good beat
	localparam logic [1:0] axi_okay = 2'b00;

	// ========================================
	// address word with two views
	// ========================================

	// the fill controller fills in the plain address, while the tag store
	// picks the same bits apart into tag, index and offset
	typedef union packed {
		logic [31:0] addr;
		struct packed {
			logic [tag_w-1:0] tag;
			logic [idx_w-1:0] index;
			logic [off_w-1:0] offset;
		} entry;
	} icache_tag_u;

	// ========================================
	// fetch side
	// ========================================

	// request held stable by the fetch unit until it gets a response
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
	} fetch_req_t;

	// insn is little endian, byte pc sits in the low eight bits
	typedef struct packed {
		logic valid;
		logic err;
		logic [31:0] pc;
		logic [insn_bytes*8-1:0] insn;
	} fetch_rsp_t;

	// ========================================
	// fill path
	// ========================================

	// line_addr always has its offset bits cleared
	typedef struct packed {
		logic start;
		logic [31:0] line_addr;
	} fill_req_t;

	// one write installs tag, valid bit and line data together
	typedef struct packed {
		logic we;
		icache_tag_u addr;
		logic [line_bytes*8-1:0] data;
	} line_wr_t;

	// ========================================
	// AXI4-Lite read channels
	// ========================================

	// arprot is tied off outside, so only valid and address travel here
	typedef struct packed {
		logic arvalid;
		logic [31:0] araddr;
	} axi_ar_t;

	typedef struct packed {
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axi_r_t;

endpackage

`default_nettype wire

// File: icache_tag_ram.sv
/*
 * tag store with two synchronous lookups per cycle, at pc and at pc+8.
 * a write in the same cycle as a lookup of that index is not forwarded,
 * so the caller has to look again one cycle after an install
 */
`default_nettype none
`timescale 1ns/1ps

module icache_tag_ram import icache_pkg::*; (
	input logic rclk,
	input logic reset,
	input line_wr_t wr,
	input logic [31:0] pc,
	output logic hit0,
	output logic hit1
);

	// tag words, kept as full line addresses like the fill writes them
	icache_tag_u tags [num_sets];
	// one valid bit per line, in flops so that reset can clear them
	logic [num_sets-1:0] valid_q;

	// both lookup addresses seen through the entry view
	icache_tag_u pc_u;
	icache_tag_u pcp8_u;

	// read results and the addresses they were read for
	icache_tag_u tag0_q;
	icache_tag_u tag1_q;
	icache_tag_u rpc_q;
	icache_tag_u rpcp8_q;
	logic v0_q;
	logic v1_q;

	// the second lookup covers the tail of a window that runs past the line
	always_comb begin
		pc_u.addr = pc;
		pcp8_u.addr = pc + 32'd8;
	end

	// ========================================
	// tag array
	// ========================================

	// the whole fill address goes in, only the tag field is compared later
	always_ff @(posedge rclk) begin
		if (wr.we) begin
			tags[wr.addr.entry.index].addr <= wr.addr.addr;
		end
	end

	// synchronous read of both entries, the pcs are kept for the compare
	always_ff @(posedge rclk) begin
		tag0_q <= tags[pc_u.entry.index];
		tag1_q <= tags[pcp8_u.entry.index];
		rpc_q <= pc_u;
		rpcp8_q <= pcp8_u;
	end

	// ========================================
	// valid bits
	// ========================================

	always_ff @(posedge rclk) begin
		if (reset) begin
			valid_q <= '0;
			v0_q <= 1'b0;
			v1_q <= 1'b0;
		end else begin
			if (wr.we) begin
				valid_q[wr.addr.entry.index] <= 1'b1;
			end
			// read alongside the tag words so both line up in the same cycle
			v0_q <= valid_q[pc_u.entry.index];
			v1_q <= valid_q[pcp8_u.entry.index];
		end
	end

	// a hit needs the line present and the stored tag matching the lookup
	assign hit0 = v0_q && (tag0_q.entry.tag == rpc_q.entry.tag);
	assign hit1 = v1_q && (tag1_q.entry.tag == rpcp8_q.entry.tag);

	// the fill controller must stay quiet until reset has been released
	a_no_write_in_reset: assert property (@(posedge rclk) wr.we |-> !reset)
		else $error("tag store written while reset is high");

endmodule

`default_nettype wire

// File: icache_data_ram.sv
/*
 * line store matching the tag store index for index. it reads the lines
 * at pc and pc+8 and hands back the 8 bytes from pc on, little endian.
 * the data is only meaningful when the tag store reports both hits
 */
`default_nettype none
`timescale 1ns/1ps

module icache_data_ram import icache_pkg::*; (
	input logic rclk,
	input line_wr_t wr,
	input logic [31:0] pc,
	output logic [insn_bytes*8-1:0] insn
);

	// one entry per line, lowest address byte in the lowest bits
	logic [line_bytes*8-1:0] lines [num_sets];

	// lookup addresses with the index field exposed
	icache_tag_u pc_u;
	icache_tag_u pcp8_u;

	// lines read on the last edge and the byte offset they were read for
	logic [line_bytes*8-1:0] line0_q;
	logic [line_bytes*8-1:0] line1_q;
	logic [off_w-1:0] off_q;

	// both lines side by side, the window never reaches past the second
	logic [2*line_bytes*8-1:0] span;

	always_comb begin
		pc_u.addr = pc;
		pcp8_u.addr = pc + 32'd8;
	end

	// ========================================
	// line array
	// ========================================

	// a fill writes the whole line in one go, in step with the tag store
	always_ff @(posedge rclk) begin
		if (wr.we) begin
			lines[wr.addr.entry.index] <= wr.data;
		end
	end

	// both reads happen every cycle, the fetch unit holds pc steady
	always_ff @(posedge rclk) begin
		line0_q <= lines[pc_u.entry.index];
		line1_q <= lines[pcp8_u.entry.index];
		off_q <= pc_u.entry.offset;
	end

	// ========================================
	// window extraction
	// ========================================

	// when the offset is below 8 both reads hit the same line, and the
	// window stays inside the lower half of the span
	assign span = {line1_q, line0_q};

	// offset in bytes times eight gives the starting bit of the window
	assign insn = span[{off_q, 3'b000} +: insn_bytes*8];

endmodule

`default_nettype wire

// File: icache_fill.sv
/*
 * fetches one line as four AXI4-Lite word reads with one read in flight.
 * only a single fill runs at a time and start is ignored while busy.
 * there is no timeout, a silent slave stalls the fill forever
 */
`default_nettype none
`timescale 1ns/1ps

module icache_fill import icache_pkg::*; (
	input logic rclk,
	input logic reset,
	input fill_req_t req,
	output axi_ar_t ar,
	input logic arready,
	input axi_r_t r,
	output logic rready,
	output line_wr_t wr,
	output logic busy,
	output logic err_pulse
);

	// address and data alternate for every beat, install lasts one cycle
	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data,
		st_install
	} state_t;

	state_t state_q;
	// index of the word being fetched within the line
	logic [beat_w-1:0] beat_q;
	// set by any beat that did not come back OKAY
	logic bad_q;
	// line base without the offset bits
	logic [31:off_w] base_q;
	// assembled line, words shift in from the top
	logic [line_bytes*8-1:0] line_q;

	// ========================================
	// control FSM
	// ========================================

	always_ff @(posedge rclk) begin
		if (reset) begin
			state_q <= st_idle;
			beat_q <= '0;
			bad_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (req.start) begin
						state_q <= st_addr;
						beat_q <= '0;
						bad_q <= 1'b0;
					end
				end
				st_addr: begin
					// the address phase ends on the AR handshake
					if (arready) begin
						state_q <= st_data;
					end
				end
				st_data: begin
					if (r.rvalid) begin
						bad_q <= bad_q | (r.rresp != axi_okay);
						if (beat_q == beat_w'(line_words - 1)) begin
							state_q <= st_install;
						end else begin
							beat_q <= beat_q + 1'b1;
							state_q <= st_addr;
						end
					end
				end
				st_install: begin
					state_q <= st_idle;
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// ========================================
	// line buffer
	// ========================================

	// after the last beat the first word has moved down to the low bits
	always_ff @(posedge rclk) begin
		if (state_q == st_idle && req.start) begin
			base_q <= req.line_addr[31:off_w];
		end
		if (state_q == st_data && r.rvalid) begin
			line_q <= {r.rdata, line_q[line_bytes*8-1:32]};
		end
	end

	// ========================================
	// outputs
	// ========================================

	// every output comes straight from registered state, so araddr cannot
	// move while a read address is waiting for arready
	always_comb begin
		ar.arvalid = (state_q == st_addr);
		ar.araddr = {base_q, beat_q, 2'b00};
		rready = (state_q == st_data);
		// a bad line is dropped, the error pulse replaces the write
		wr.we = (state_q == st_install) && !bad_q;
		wr.addr.addr = {base_q, {off_w{1'b0}}};
		wr.data = line_q;
		err_pulse = (state_q == st_install) && bad_q;
		busy = (state_q != st_idle);
	end

	// AXI rule, a pending read address holds until it is taken
	a_araddr_stable: assert property (@(posedge rclk) disable iff (reset)
		(ar.arvalid && !arready) |=> (ar.arvalid && $stable(ar.araddr)))
		else $error("araddr changed while waiting for arready");

	// the top must wait for idle before asking for the next line
	a_no_start_busy: assert property (@(posedge rclk) disable iff (reset)
		busy |-> !req.start)
		else $error("fill start seen while a fill is running");

endmodule

`default_nettype wire

// File: icache_top.sv
/*
 * instruction cache front end with a fetch port and an AXI4-Lite read port.
 * the fetch unit must hold its request until a response for that pc.
 * hits answer one cycle after the request, misses wait for one or two fills
 */
`default_nettype none
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input logic rclk,
	input logic reset,
	input fetch_req_t req,
	output fetch_rsp_t rsp,
	output axi_ar_t ar,
	input logic arready,
	input axi_r_t r,
	output logic rready
);

	// lookup register, lines up with the stores' registered reads
	fetch_req_t req_q;
	// blocks the cycle after an install or a response
	logic skip_q;

	logic hit0;
	logic hit1;
	logic [insn_bytes*8-1:0] insn;
	logic busy;
	logic err_pulse;
	logic [31:0] pc_next;
	logic lookup_ok;
	fill_req_t fill_req;
	line_wr_t line_wr;

	// ========================================
	// lookup register
	// ========================================

	always_ff @(posedge rclk) begin
		if (reset) begin
			req_q.valid <= 1'b0;
			skip_q <= 1'b0;
		end else begin
			req_q.valid <= req.valid;
			// after an install the stores still show the old line for one
			// cycle, and after a response the held request is stale
			skip_q <= line_wr.we || rsp.valid;
		end
	end

	always_ff @(posedge rclk) begin
		req_q.pc <= req.pc;
	end

	// ========================================
	// miss handling
	// ========================================

	assign pc_next = req_q.pc + 32'd8;
	assign lookup_ok = req_q.valid && !busy && !skip_q;

	// the lower line goes first, the upper one only once the lower hits
	always_comb begin
		fill_req.start = lookup_ok && !(hit0 && hit1);
		if (hit0) begin
			fill_req.line_addr = {pc_next[31:off_w], {off_w{1'b0}}};
		end else begin
			fill_req.line_addr = {req_q.pc[31:off_w], {off_w{1'b0}}};
		end
	end

	// a failed fill answers the held request with err set
	always_comb begin
		rsp.valid = (lookup_ok && hit0 && hit1) || (req_q.valid && err_pulse);
		rsp.err = err_pulse;
		rsp.pc = req_q.pc;
		rsp.insn = insn;
	end

	// ========================================
	// stores and fill controller
	// ========================================

	// both stores register the pc they read with, as the lookup register does
	icache_tag_ram u_tag_ram (
		.rclk(rclk),
		.reset(reset),
		.wr(line_wr),
		.pc(req.pc),
		.hit0(hit0),
		.hit1(hit1)
	);

	icache_data_ram u_data_ram (
		.rclk(rclk),
		.wr(line_wr),
		.pc(req.pc),
		.insn(insn)
	);

	icache_fill u_fill (
		.rclk(rclk),
		.reset(reset),
		.req(fill_req),
		.ar(ar),
		.arready(arready),
		.r(r),
		.rready(rready),
		.wr(line_wr),
		.busy(busy),
		.err_pulse(err_pulse)
	);

endmodule

`default_nettype wire

// File: icache_tb.sv
/*
 * testbench for the instruction cache, run from the project root so that
 * icache_vectors.txt is found. the AXI slave answers every word address
 * with the address xor 32'h5a5a0000 after random delays of 0 to 3 cycles
 */
`default_nettype none
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

	localparam int clk_half = 4;
	localparam int max_tests = 64;
	localparam int cycles_per_test = 200;
	localparam logic [31:0] data_mask = 32'h5a5a0000;
	localparam logic [1:0] axi_slverr = 2'b10;

	logic rclk;
	logic reset;
	fetch_req_t req;
	fetch_rsp_t rsp;
	axi_ar_t ar;
	logic arready;
	axi_r_t r;
	logic rready;

	// three words per test: pc, expected fills, error flag
	logic [31:0] vec_mem [0:3*max_tests-1];
	int n_tests;
	int error_count;
	int check_count;
	// AR handshakes seen during the current test
	int ar_count;
	logic run_started;
	// the slave model needs the current pc and flag to decide on SLVERR
	logic [31:0] cur_pc;
	logic cur_flag;
	logic [31:0] lfsr_q;

	icache_top u_icache_top (
		.rclk(rclk),
		.reset(reset),
		.req(req),
		.rsp(rsp),
		.ar(ar),
		.arready(arready),
		.r(r),
		.rready(rready)
	);

	always #clk_half rclk = ~rclk;

	// ========================================
	// helpers
	// ========================================

	// x^32 + x^22 + x^2 + x + 1, shifting towards the high end
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// two bits from the LFSR give a wait of 0 to 3 cycles
	task automatic take_delay(output int d);
		d = 0;
		for (int i = 0; i < 2; i++) begin
			d = (d << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// byte b of memory is byte b[1:0] of the word at b with the mask applied
	function automatic logic [63:0] window_bytes(input logic [31:0] pc);
		logic [63:0] w;
		logic [31:0] a;
		logic [31:0] word;
		for (int i = 0; i < insn_bytes; i++) begin
			a = pc + i;
			word = {a[31:2], 2'b00} ^ data_mask;
			w[8*i +: 8] = word[8*a[1:0] +: 8];
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ========================================
	// AXI4-Lite read slave
	// ========================================

	// one read at a time, outputs sampled at the falling edge, inputs
	// driven 1 ns after the rising edge
	initial begin : axi_slave
		int d;
		logic [31:0] addr;
		forever begin
			@(negedge rclk);
			if (ar.arvalid === 1'b1) begin
				addr = ar.araddr;
				take_delay(d);
				repeat (d) @(negedge rclk);
				@(posedge rclk);
				#1;
				arready = 1'b1;
				@(negedge rclk);
				// the address must still be waiting, unchanged
				check_value("arvalid", ar.arvalid, 1);
				check_value("araddr", ar.araddr, addr);
				@(posedge rclk);
				ar_count++;
				#1;
				arready = 1'b0;
				take_delay(d);
				repeat (d) begin
					@(posedge rclk);
					#1;
				end
				r.rvalid = 1'b1;
				r.rdata = addr ^ data_mask;
				// the flag spoils only the lower line of the current fetch
				if (cur_flag && addr[31:4] == cur_pc[31:4]) begin
					r.rresp = axi_slverr;
				end else begin
					r.rresp = axi_okay;
				end
				@(negedge rclk);
				check_value("rready", rready, 1);
				@(posedge rclk);
				#1;
				r = '0;
			end
		end
	end

	// ========================================
	// one fetch per vector
	// ========================================

	task automatic run_test(input int idx);
		logic [31:0] pc;
		int exp_fills;
		int cycles;
		int errors_before;
		pc = vec_mem[3*idx];
		exp_fills = vec_mem[3*idx+1];
		errors_before = error_count;
		cur_pc = pc;
		cur_flag = vec_mem[3*idx+2][0];
		ar_count = 0;
		cycles = 0;
		req.valid = 1'b1;
		req.pc = pc;
		// count rising edges until the response shows up
		do begin
			@(posedge rclk);
			cycles++;
			@(negedge rclk);
		end while (rsp.valid !== 1'b1);
		check_value("rsp.pc", rsp.pc, pc);
		check_value("rsp.err", rsp.err, cur_flag);
		if (!cur_flag) begin
			check_value("rsp.insn", rsp.insn, window_bytes(pc));
		end
		// every fill is four word reads
		check_value("ar handshakes", ar_count, exp_fills * 4);
		if (exp_fills == 0) begin
			check_value("hit latency", cycles, 1);
		end
		@(posedge rclk);
		#1;
		req.valid = 1'b0;
		req.pc = '0;
		@(posedge rclk);
		#1;
		if (error_count == errors_before) begin
			$display("vector %0d pc %08h fills %0d: ok", idx, pc, exp_fills);
		end else begin
			$display("vector %0d pc %08h fills %0d: mismatch", idx, pc, exp_fills);
		end
	endtask

	initial begin
		rclk = 1'b0;
		reset = 1'b1;
		req = '0;
		arready = 1'b0;
		r = '0;
		lfsr_q = 32'hd41c;
		n_tests = 0;
		error_count = 0;
		check_count = 0;
		ar_count = 0;
		run_started = 1'b0;
		cur_pc = '0;
		cur_flag = 1'b0;
		$readmemh("icache_vectors.txt", vec_mem);
		while (n_tests < max_tests && !$isunknown(vec_mem[3*n_tests])) begin
			n_tests++;
		end
		run_started = 1'b1;
		repeat (5) @(posedge rclk);
		#1;
		reset = 1'b0;
		if (n_tests == 0) begin
			$display("no vectors could be read from icache_vectors.txt");
			error_count++;
		end else begin
			for (int i = 0; i < n_tests; i++) begin
				run_test(i);
			end
		end
		$display("vectors %0d, checks %0d, errors %0d", n_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// ========================================
	// watchdog
	// ========================================

	// a budget per vector plus some room for reset and the final report
	initial begin : watchdog
		wait (run_started);
		#((n_tests * cycles_per_test + 20) * 2 * clk_half);
		$display("timeout, the cache stopped answering before all vectors were run");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: icache_vectors.txt
// columns: fetch pc, expected line fills, 1 to answer the lower line with SLVERR
// index is pc bits 11:4, a window with offset 8 or more needs the next line too
00001000 1 0
00001000 0 0
00001004 0 0
// cross-line with both lines absent, then a hit on the pair
0000102a 2 0
0000102a 0 0
0000103c 1 0
// same index with another tag evicts, the old address misses again
00005000 1 0
00005000 0 0
00001000 1 0
// failed fill installs nothing, the retry fills and succeeds
00002100 1 1
00002100 1 0
00002100 0 0
0000a1f8 2 0
0000a1f8 0 0
0000aff4 1 1
0000aff4 1 0
0000affc 1 0
00001008 2 0
00001008 0 0
0000b000 1 0
// error on the lower line of a cross-line fetch stops after one fill
00003ff8 1 1
00003ff8 2 0
00003ff8 0 0
0000fff0 1 0
0000aff4 1 0
// the upper line wraps around to address zero
fffffffc 2 0
fffffffc 0 0
00000000 0 0

// File: icache_top.f
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_fill.sv
icache_top.sv
icache_tb.sv
